//--- logic/game_pkg.sv
`default_nettype none

package game_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes and limits
    //////////////////////////////////////////////////////////////////////

    localparam int POS_W = 12;                       // one coordinate word.
    localparam int CNT_W = 16;
    localparam int WB_DW = 32;

    localparam logic [POS_W-1:0] X_MAX   = 12'd639;
    localparam logic [POS_W-1:0] GATE_LO = 12'd300;  // zone is (GATE_LO, GATE_HI].
    localparam logic [POS_W-1:0] GATE_HI = 12'd400;
    localparam logic [POS_W-1:0] JUMP_H  = 12'd16;   // peak of the arc.

    // word addresses, taken from adr[3:2]
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_POS    = 2'd1;
    localparam logic [1:0] REG_FLAGS  = 2'd2;
    localparam logic [1:0] REG_FRAMES = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RIGHT = 2'd1,
        LEFT  = 2'd2
    } move_state_t;

    typedef struct packed {
        logic left;
        logic right;
        logic button;
        logic jump;
    } ctl_t;

    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] height;
    } pos_t;

    typedef struct packed {
        pos_t             pos;
        logic             in_zone;
        logic             airborne;
        logic [CNT_W-1:0] step_count;
        logic [CNT_W-1:0] landing_count;
    } status_t;

    // true when a coordinate lies inside the gate zone.
    function automatic logic in_gate(input logic [POS_W-1:0] xv);
        return (xv > GATE_LO) && (xv <= GATE_HI);
    endfunction

endpackage

`default_nettype wire

//--- logic/wb_game_regs.sv
`timescale 1ns/10ps
`default_nettype none

module wb_game_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [3:0]          adr,
    input  logic [31:0]         dat_w,
    output logic                ack,
    output logic [31:0]         dat_r,
    input  logic                v_tick,
    input  game_pkg::status_t   status,
    output game_pkg::ctl_t      ctl,
    output logic                frame
);

    import game_pkg::*;

    logic             v_tick_q;
    logic [WB_DW-1:0] frame_count;
    logic             access;
    logic [1:0]       reg_sel;

    //////////////////////////////////////////////////////////////////////
    // wishbone classic slave
    //////////////////////////////////////////////////////////////////////

    assign access  = cyc && stb && !ack;  // new strobe, not yet acked.
    assign reg_sel = adr[3:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            ctl <= '0;
        end else begin
            ack <= access;                // single cycle ack.
            if (access && we && (reg_sel == REG_CTRL)) begin
                ctl <= ctl_t'(dat_w[3:0]);
            end
        end
    end

    // address held by the master until ack, so a plain mux is enough
    always_comb begin
        dat_r = '0;
        case (reg_sel)
            REG_CTRL: begin
                dat_r[3:0] = ctl;
                dat_r[8]   = status.in_zone;
                dat_r[9]   = status.airborne;
            end
            REG_POS: begin
                dat_r[POS_W-1:0]   = status.pos.x;
                dat_r[16 +: POS_W] = status.pos.height;
            end
            REG_FLAGS: begin
                dat_r[15:0]  = status.step_count;
                dat_r[31:16] = status.landing_count;
            end
            REG_FRAMES: begin
                dat_r = frame_count;
            end
            default: begin
                dat_r = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // frame tick
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            v_tick_q    <= 1'b0;
            frame       <= 1'b0;
            frame_count <= '0;
        end else begin
            v_tick_q <= v_tick;
            frame    <= v_tick && !v_tick_q;   // rising edge only.
            if (frame) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/player_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module player_ctl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         frame,
    input  game_pkg::ctl_t               ctl,
    output logic [game_pkg::POS_W-1:0]   x
);

    import game_pkg::*;

    move_state_t      state;
    move_state_t      state_nxt;
    logic [POS_W-1:0] x_nxt;
    logic [POS_W-1:0] x_up;
    logic [POS_W-1:0] x_dn;
    logic             step_r;
    logic             step_l;

    assign x_up = x + 1'b1;
    assign x_dn = x - 1'b1;

    // button must be held exactly when the target is in the gate zone
    assign step_r = ctl.right && (x < X_MAX) && (ctl.button == in_gate(x_up));
    assign step_l = ctl.left && (x != '0) && (ctl.button == in_gate(x_dn));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            x     <= '0;
        end else if (frame) begin
            state <= state_nxt;
            x     <= x_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        x_nxt     = x;
        case (state)
            IDLE: begin
                if (ctl.right) begin
                    state_nxt = RIGHT;     // right wins over left.
                end else if (ctl.left) begin
                    state_nxt = LEFT;
                end
            end
            RIGHT: begin
                if (step_r) begin
                    x_nxt = x_up;
                end else begin
                    state_nxt = IDLE;      // refused step, x holds.
                end
            end
            LEFT: begin
                if (step_l) begin
                    x_nxt = x_dn;
                end else begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/jump_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module jump_ctl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         frame,
    input  game_pkg::ctl_t               ctl,
    output logic [game_pkg::POS_W-1:0]   height
);

    import game_pkg::*;

    logic rising;

    //////////////////////////////////////////////////////////////////////
    // jump arc, up JUMP_H frames then down JUMP_H frames
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rising <= 1'b0;
            height <= '0;
        end else if (frame) begin
            if (rising) begin
                height <= height + 1'b1;
                if (height == JUMP_H - 1'b1) begin
                    rising <= 1'b0;        // peak reached this frame.
                end
            end else if (height != '0) begin
                height <= height - 1'b1;
            end else if (ctl.jump) begin
                height <= 12'd1;           // take off from ground.
                rising <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/player_status.sv
`timescale 1ns/10ps
`default_nettype none

module player_status (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [game_pkg::POS_W-1:0]   x,
    input  logic [game_pkg::POS_W-1:0]   height,
    output game_pkg::status_t            status
);

    import game_pkg::*;

    logic moved;
    logic landed;

    assign moved  = (x != status.pos.x);
    assign landed = (height == '0) && (status.pos.height == 12'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            status.pos.x      <= x;
            status.pos.height <= height;
            status.in_zone    <= in_gate(x);
            status.airborne   <= (height != '0);
            if (moved) begin
                status.step_count <= status.step_count + 1'b1;
            end
            if (landed) begin
                status.landing_count <= status.landing_count + 1'b1;  // back on ground.
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/player_top.sv
`timescale 1ns/10ps
`default_nettype none

module player_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  adr,
    input  logic [31:0] dat_w,
    output logic        ack,
    output logic [31:0] dat_r,
    input  logic        v_tick
);

    import game_pkg::*;

    ctl_t             ctl;
    status_t          status;
    logic             frame;
    logic [POS_W-1:0] x;
    logic [POS_W-1:0] height;

    wb_game_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .ack    (ack),
        .dat_r  (dat_r),
        .v_tick (v_tick),
        .status (status),
        .ctl    (ctl),
        .frame  (frame)
    );

    // horizontal and vertical motion run side by side
    player_ctl u_player_ctl (
        .clk   (clk),
        .rst   (rst),
        .frame (frame),
        .ctl   (ctl),
        .x     (x)
    );

    jump_ctl u_jump_ctl (
        .clk    (clk),
        .rst    (rst),
        .frame  (frame),
        .ctl    (ctl),
        .height (height)
    );

    player_status u_status (
        .clk    (clk),
        .rst    (rst),
        .x      (x),
        .height (height),
        .status (status)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;  // 20 ns period.

endmodule

`default_nettype wire

//--- verif/player_checker.sv
`timescale 1ns/10ps
`default_nettype none

module player_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  adr,
    input  logic        ack,
    input  logic [31:0] dat_r,
    input  logic [31:0] exp_data,
    input  logic        test_end,
    input  int          test_id,
    output int          test_count,
    output int          fail_count,
    output int          error_count
);

    import game_pkg::*;

    logic ack_q = 1'b0;
    int   tests = 0;
    int   failed = 0;
    int   errors = 0;
    int   test_errors = 0;

    assign test_count  = tests;
    assign fail_count  = failed;
    assign error_count = errors;

    function automatic string reg_name(input logic [1:0] sel);
        case (sel)
            REG_CTRL:  return "REG_CTRL";
            REG_POS:   return "REG_POS";
            REG_FLAGS: return "REG_FLAGS";
            default:   return "REG_FRAMES";
        endcase
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            if (ack && ack_q) begin
                $display("ack stayed high for two cycles at %0t", $time);
                errors      = errors + 1;
                test_errors = test_errors + 1;
            end
            // read data is valid in the ack cycle.
            if (cyc && stb && ack && !we && (dat_r !== exp_data)) begin
                $display("Fail %0t: %s read %h, expected %h",
                         $time, reg_name(adr[3:2]), dat_r, exp_data);
                errors      = errors + 1;
                test_errors = test_errors + 1;
            end
            if (test_end) begin
                tests = tests + 1;
                if (test_errors == 0) begin
                    $display("test %0d passed", test_id);
                end else begin
                    $display("test %0d failed with %0d mismatches", test_id, test_errors);
                    failed = failed + 1;
                end
                test_errors = 0;
            end
        end
        ack_q <= ack;
    end

endmodule

`default_nettype wire

//--- verif/player_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module player_asserts (
    input logic       clk,
    input logic       rst,
    input logic       cyc,
    input logic       stb,
    input logic       we,
    input logic [3:0] adr,
    input logic       ack,
    input logic       v_tick,
    input logic       frame
);

    ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held longer than one cycle");

    // master keeps the request steady until ack
    req_held: assert property (@(posedge clk) disable iff (rst)
        (cyc && stb && !ack) |=> (cyc && stb && $stable(adr) && $stable(we)))
        else $error("request changed before ack");

    frame_single: assert property (@(posedge clk) disable iff (rst) frame |=> !frame)
        else $error("frame pulse longer than one cycle");

    // v_tick comes as a level, not a one-cycle glitch
    tick_level: assert property (@(posedge clk) disable iff (rst)
        $rose(v_tick) |=> v_tick)
        else $error("v_tick high for a single cycle");

endmodule

bind wb_game_regs player_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .ack    (ack),
    .v_tick (v_tick),
    .frame  (frame)
);

`default_nettype wire

//--- verif/player_tb.sv
`timescale 1ns/10ps
`default_nettype none

module player_tb;

    import game_pkg::*;

    typedef struct packed {
        logic [3:0]       ctrl;      // left, right, button, jump.
        logic [15:0]      frames;
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] height;
        logic [15:0]      steps;
        logic [15:0]      landings;
    } row_t;

    row_t        table_rows [12];
    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
    logic        ack;
    logic [31:0] dat_r;
    logic        v_tick = 1'b0;
    logic        tick_en = 1'b0;
    logic [3:0]  phase = 4'd0;
    int          tick_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 200;
    int          frame_base;
    logic [31:0] exp_data;
    logic        test_end;
    int          test_id;
    int          test_count;
    int          fail_count;
    int          error_count;

    tb_clock clock_gen (.clk(clk));

    player_top uut (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .ack    (ack),
        .dat_r  (dat_r),
        .v_tick (v_tick)
    );

    player_checker chk (
        .clk         (clk),
        .rst         (rst),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .ack         (ack),
        .dat_r       (dat_r),
        .exp_data    (exp_data),
        .test_end    (test_end),
        .test_id     (test_id),
        .test_count  (test_count),
        .fail_count  (fail_count),
        .error_count (error_count)
    );

    //////////////////////////////////////////////////////////////////////
    // v_tick every 16 cycles, high for 4
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (tick_en) begin
            phase <= phase + 4'd1;
            if (phase == 4'd11) begin
                v_tick     <= 1'b1;
                tick_count <= tick_count + 1;
            end else if (phase == 4'd15) begin
                v_tick <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_table();
        // ctrl, frames, x, height, step_count, landing_count
        table_rows[0]  = '{4'b0100, 16'd305, 12'd300, 12'd0,  16'd300, 16'd0};
        table_rows[1]  = '{4'b0000, 16'd2,   12'd300, 12'd0,  16'd300, 16'd0};
        table_rows[2]  = '{4'b0110, 16'd102, 12'd400, 12'd0,  16'd400, 16'd0};
        table_rows[3]  = '{4'b0100, 16'd50,  12'd449, 12'd0,  16'd449, 16'd0};
        table_rows[4]  = '{4'b0000, 16'd2,   12'd449, 12'd0,  16'd449, 16'd0};
        table_rows[5]  = '{4'b1000, 16'd60,  12'd401, 12'd0,  16'd497, 16'd0};
        table_rows[6]  = '{4'b1010, 16'd102, 12'd301, 12'd0,  16'd597, 16'd0};
        table_rows[7]  = '{4'b1000, 16'd310, 12'd0,   12'd0,  16'd898, 16'd0};
        table_rows[8]  = '{4'b0000, 16'd2,   12'd0,   12'd0,  16'd898, 16'd0};
        table_rows[9]  = '{4'b0001, 16'd10,  12'd0,   12'd10, 16'd898, 16'd0};
        table_rows[10] = '{4'b0001, 16'd22,  12'd0,   12'd0,  16'd898, 16'd1};
        table_rows[11] = '{4'b0000, 16'd2,   12'd0,   12'd0,  16'd898, 16'd1};
    endtask

    // control bits with zone and airborne flags, as REG_CTRL reads back.
    function automatic logic [31:0] ctrl_word(input row_t row);
        logic in_zone;
        logic airborne;
        in_zone  = (row.x > GATE_LO) && (row.x <= GATE_HI);
        airborne = (row.height != '0);
        return {22'd0, airborne, in_zone, 4'd0, row.ctrl};
    endfunction

    task automatic bus_write(input logic [1:0] sel, input logic [31:0] data);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= {sel, 2'b00};
        dat_w <= data;
        @(posedge clk);
        while (!ack) @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic bus_read(input logic [1:0] sel, input logic [31:0] expected);
        exp_data <= expected;
        cyc      <= 1'b1;
        stb      <= 1'b1;
        we       <= 1'b0;
        adr      <= {sel, 2'b00};
        @(posedge clk);
        while (!ack) @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_frames(input int target);
        while (tick_count < target) @(posedge clk);
        repeat (4) @(posedge clk);  // status settles two cycles after frame.
    endtask

    task automatic finish_test(input int id);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = 4'd0;
        dat_w    = 32'd0;
        exp_data = 32'd0;
        test_end = 1'b0;
        test_id  = 0;
        load_table();
        foreach (table_rows[i]) begin
            cycle_limit = cycle_limit + 16 * int'(table_rows[i].frames);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int r = 0; r < 4; r++) begin
            bus_read(2'(r), 32'd0);
        end
        finish_test(0);
        tick_en <= 1'b1;
        foreach (table_rows[i]) begin
            frame_base = tick_count;  // ticks during the write act on the new value.
            bus_write(REG_CTRL, {28'd0, table_rows[i].ctrl});
            wait_frames(frame_base + int'(table_rows[i].frames));
            bus_read(REG_POS, {4'd0, table_rows[i].height, 4'd0, table_rows[i].x});
            bus_read(REG_FLAGS, {table_rows[i].landings, table_rows[i].steps});
            bus_read(REG_CTRL, ctrl_word(table_rows[i]));
            finish_test(i + 1);
        end
        bus_read(REG_FRAMES, tick_count);
        finish_test($size(table_rows) + 1);
        repeat (2) @(posedge clk);
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 test_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0 && test_count == $size(table_rows) + 2) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/game_pkg.sv
logic/wb_game_regs.sv
logic/player_ctl.sv
logic/jump_ctl.sv
logic/player_status.sv
logic/player_top.sv
verif/tb_clock.sv
verif/player_checker.sv
verif/player_asserts.sv
verif/player_tb.sv

//--- Makefile
TOP = player_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
